/* cpu_core.f */
rtl/core_pkg.sv
rtl/program_counter.sv
rtl/memory.sv
rtl/instruction_decode.sv
rtl/register_file.sv
rtl/alu.sv
rtl/core.sv
tb/core_assertions.sv
tb/core_tb.sv

/* Makefile */
TOP = core_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f cpu_core.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "simulation ended without a verdict"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f cpu_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* tb/core_golden.txt */
# P address word (hex), E pc rd data (hex) and test number, F fault and retirement count
# text after the fields is ignored and names the instruction
P 00000000 800000b7 lui   x1, 0x80000
P 00000004 ffb00113 addi  x2, x0, -5
P 00000008 00700193 addi  x3, x0, 7
P 0000000c 40218233 sub   x4, x3, x2
P 00000010 003122b3 slt   x5, x2, x3
P 00000014 00313333 sltu  x6, x2, x3
P 00000018 4040d393 srai  x7, x1, 4
P 0000001c 0040d413 srli  x8, x1, 4
P 00000020 003194b3 sll   x9, x3, x3
P 00000024 0f014513 xori  x10, x2, 0xf0
P 00000028 003265b3 or    x11, x4, x3
P 0000002c 00957633 and   x12, x10, x9
P 00000030 00001697 auipc x13, 0x1
P 00000034 00518013 addi  x0, x3, 5
P 00000038 00300733 add   x14, x0, x3
P 0000003c f8a4a023 sw    x10, -128(x9)
P 00000040 f804a783 lw    x15, -128(x9)
P 00000044 00e18463 beq   x3, x14, +8
P 0000004c 00e19463 bne   x3, x14, +8
P 00000050 00419463 bne   x3, x4, +8
P 00000058 00418463 beq   x3, x4, +8
P 0000005c 00c000ef jal   x1, +12
P 00000068 01108167 jalr  x2, 17(x1)
P 00000070 00110293 addi  x5, x2, 1
P 00000074 00000000 illegal opcode
E 00000000 1 80000000 2
E 00000004 2 fffffffb 1
E 00000008 3 00000007 1
E 0000000c 4 0000000c 1
E 00000010 5 00000001 1
E 00000014 6 00000000 1
E 00000018 7 f8000000 1
E 0000001c 8 08000000 1
E 00000020 9 00000380 1
E 00000024 a ffffff0b 1
E 00000028 b 0000000f 1
E 0000002c c 00000300 1
E 00000030 d 00001030 2
E 00000034 0 00000000 2
E 00000038 e 00000007 2
E 0000003c 0 00000000 3
E 00000040 f ffffff0b 3
E 00000044 0 00000000 4
E 0000004c 0 00000000 4
E 00000050 0 00000000 4
E 00000058 0 00000000 4
E 0000005c 1 00000060 4
E 00000068 2 0000006c 4
E 00000070 5 0000006d 4
F 1 24

/* tb/core_tb.sv */
`timescale 1ns/1ns

module core_tb;

    localparam int    MEM_WORDS = 256;
    localparam int    STAGES = 6;
    localparam int    SETTLE_CYCLES = 12;
    localparam int    NUM_TESTS = 6;
    localparam string GOLDEN_FILE = "tb/core_golden.txt";

    logic        clk;
    logic        reset;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        fault;
    logic        retire;
    logic [31:0] retire_pc;
    logic [3:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] image [MEM_WORDS];
    logic [31:0] exp_pc [$];
    logic [3:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          exp_test [$];
    logic        exp_fault;
    int          exp_count;
    int          errors;
    int          test_errors [NUM_TESTS];
    bit          test_reported [NUM_TESTS];

    core #(
        .MEM_WORDS(MEM_WORDS)
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .fault(fault),
        .retire(retire),
        .retire_pc(retire_pc),
        .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic string test_name(input int n);
        case (n)
            1:       return "arithmetic and logic";
            2:       return "upper immediates and x0";
            3:       return "store and load";
            4:       return "branches and jumps";
            5:       return "retire timing";
            default: return "fault stop";
        endcase
    endfunction

    function automatic void record_error(input int n);
        errors++;
        test_errors[n - 1]++;
    endfunction

    function automatic void report_test(input int n);
        if (test_errors[n - 1] == 0) begin
            $display("test %0d %s: ok", n, test_name(n));
        end else begin
            $display("test %0d %s: %0d errors", n, test_name(n), test_errors[n - 1]);
        end
        test_reported[n - 1] = 1'b1;
    endfunction

    // a test ends with the last retirement that belongs to it
    function automatic bit last_of_test(input int idx);
        for (int j = idx + 1; j < exp_test.size(); j++) begin
            if (exp_test[j] == exp_test[idx]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic void check_retirement(input int idx);
        int n;
        n = exp_test[idx];
        if (retire_pc !== exp_pc[idx]) begin
            $display("CHECK FAILED retire_pc at retirement %0d: expected 0x%08h, got 0x%08h",
                     idx, exp_pc[idx], retire_pc);
            record_error(n);
        end
        if (retire_rd !== exp_rd[idx]) begin
            $display("CHECK FAILED retire_rd at retirement %0d: expected 0x%01h, got 0x%01h",
                     idx, exp_rd[idx], retire_rd);
            record_error(n);
        end
        if (retire_data !== exp_data[idx]) begin
            $display("CHECK FAILED retire_data at retirement %0d: expected 0x%08h, got 0x%08h",
                     idx, exp_data[idx], retire_data);
            record_error(n);
        end
        if (last_of_test(idx)) begin
            report_test(n);
        end
    endfunction

    task automatic read_golden();
        int          fd;
        int          group;
        int          count;
        int          word_index;
        string       line;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the golden file %s", GOLDEN_FILE);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0) begin
                case (line[0])
                    "P": begin
                        word_index = MEM_WORDS;
                        if ($sscanf(line, "P %h %h", f1, f2) == 2) begin
                            word_index = int'(f1 >> 2);
                        end
                        if (word_index < MEM_WORDS) begin
                            image[word_index] = f2;
                        end else begin
                            $display("unusable program line in golden file: %s", line);
                            errors++;
                        end
                    end
                    "E": begin
                        if ($sscanf(line, "E %h %h %h %d", f1, f2, f3, group) == 4 &&
                            group >= 1 && group <= 4) begin
                            exp_pc.push_back(f1);
                            exp_rd.push_back(f2[3:0]);
                            exp_data.push_back(f3);
                            exp_test.push_back(group);
                        end else begin
                            $display("unusable retire line in golden file: %s", line);
                            errors++;
                        end
                    end
                    "F": begin
                        if ($sscanf(line, "F %h %d", f1, count) == 2) begin
                            exp_fault = f1[0];
                            exp_count = count;
                        end else begin
                            $display("unusable fault line in golden file: %s", line);
                            errors++;
                        end
                    end
                    default: ;
                endcase
            end
        end
        $fclose(fd);
    endtask

    // every word goes through the load port, program words over the random fill
    task automatic load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= 32'(i * 4);
            load_data <= image[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    initial begin
        int cycle;
        int retired;
        int limit;
        int settle;
        int failed_tests;
        bit fault_seen;
        bit timed_out;
        reset = 1'b1;
        load_en = 1'b0;
        load_addr = 32'd0;
        load_data = 32'd0;
        errors = 0;
        exp_fault = 1'b0;
        exp_count = 0;
        for (int n = 0; n < NUM_TESTS; n++) begin
            test_errors[n] = 0;
            test_reported[n] = 1'b0;
        end
        void'($urandom(32'h474f));
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = $urandom();
        end
        read_golden();
        // reset covers the whole load and then ten idle cycles
        load_memory();
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        limit = STAGES * exp_count + 100;
        cycle = 0;
        retired = 0;
        settle = 0;
        fault_seen = 1'b0;
        timed_out = 1'b0;
        // cycle 0 is the first cycle with reset low, so retirement n lands in cycle 6 * (n + 1)
        while (settle < SETTLE_CYCLES && !timed_out) begin
            @(negedge clk);
            if (retire) begin
                if (fault_seen) begin
                    $display("a retirement at pc 0x%08h came after the fault", retire_pc);
                    record_error(6);
                end else if (retired >= exp_count) begin
                    $display("unexpected extra retirement at pc 0x%08h", retire_pc);
                    record_error(6);
                end else begin
                    check_retirement(retired);
                    if (cycle != STAGES * (retired + 1)) begin
                        $display("retirement %0d came in cycle %0d instead of cycle %0d",
                                 retired, cycle, STAGES * (retired + 1));
                        record_error(5);
                    end
                end
                retired++;
            end
            if (fault) begin
                fault_seen = 1'b1;
            end
            if (fault_seen || retired >= exp_count) begin
                settle++;
            end
            cycle++;
            if (cycle >= limit) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            record_error(5);
        end
        if (fault !== exp_fault) begin
            $display("CHECK FAILED fault: expected 0x%01h, got 0x%01h", exp_fault, fault);
            record_error(6);
        end
        if (retired != exp_count) begin
            $display("CHECK FAILED retire count: expected 0x%0h, got 0x%0h", exp_count, retired);
            record_error(6);
        end
        for (int n = 1; n <= NUM_TESTS; n++) begin
            if (!test_reported[n - 1]) begin
                report_test(n);
            end
        end
        failed_tests = 0;
        for (int n = 0; n < NUM_TESTS; n++) begin
            if (test_errors[n] != 0) begin
                failed_tests++;
            end
        end
        $display("tests run %0d, tests failed %0d, retirements %0d, errors %0d",
                 NUM_TESTS, failed_tests, retired, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tb/core_assertions.sv */
`timescale 1ns/1ns

module core_assertions import core_pkg::*; (
    input logic   clk,
    input logic   reset,
    input stage_t stage,
    input logic   retire,
    input logic   fault
);

    stage_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(stage))
        else $error("stage register is not one-hot: %b", stage);

    retire_in_write_back: assert property (@(posedge clk) disable iff (reset)
        retire |-> stage == WRITE_BACK)
        else $error("retire pulse outside the write-back stage");

    // the sequencer is frozen once a fault is taken
    no_retire_after_fault: assert property (@(posedge clk) disable iff (reset)
        fault |-> !retire)
        else $error("retire pulse while fault is high");

    fault_sticky: assert property (@(posedge clk) disable iff (reset) fault |=> fault)
        else $error("fault fell without a reset");

endmodule

bind core core_assertions core_checks (
    .clk(clk),
    .reset(reset),
    .stage(stage),
    .retire(retire),
    .fault(fault)
);

/* rtl/core.sv */
`timescale 1ns/1ns

module core import core_pkg::*; #(
    parameter int          MEM_WORDS = 256,
    parameter logic [31:0] RESET_PC  = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    output logic        fault,
    output logic        retire,
    output logic [31:0] retire_pc,
    output logic [3:0]  retire_rd,
    output logic [31:0] retire_data
);

    stage_t      stage;
    stage_t      stage_next;
    logic        fault_next;

    logic        pc_en;
    logic        mem_en;
    logic        dec_en;
    logic        rf_read_en;
    logic        rf_write_en;
    logic        alu_en;

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        pc_fault;
    logic        branch_taken;

    logic [31:0] mem_addr;
    logic        mem_write;
    instr_t      mem_read_data;
    logic        mem_fault;

    logic [31:0] dec_imm;
    logic [3:0]  dec_rs1;
    logic [3:0]  dec_rs2;
    logic [3:0]  dec_rd;
    logic        dec_rd_write;
    logic        dec_alu_a_pc;
    logic        dec_alu_b_imm;
    alu_op_t     dec_alu_op;
    logic        dec_mem_read;
    logic        dec_mem_write;
    wb_sel_t     dec_wb_sel;
    pc_sel_t     dec_pc_sel;
    logic        dec_branch_ne;
    logic        dec_fault;

    logic [31:0] rf_read_a;
    logic [31:0] rf_read_b;
    logic [31:0] wb_data;

    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_equal;

    // a fault raised by any block in this stage is taken on the closing edge
    assign fault_next = fault || pc_fault || mem_fault || dec_fault;

    always_comb begin
        if (fault_next) begin
            stage_next = stage;
        end else begin
            stage_next = stage_t'({stage[4:0], stage[5]});
        end
    end

    // reset parks the sequencer in WRITE_BACK, so the first rotation lands on FETCH
    // each enable is registered from the next stage and is high through that stage
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= WRITE_BACK;
            fault <= 1'b0;
            pc_en <= 1'b0;
            mem_en <= 1'b0;
            dec_en <= 1'b0;
            rf_read_en <= 1'b0;
            rf_write_en <= 1'b0;
            alu_en <= 1'b0;
        end else begin
            stage <= stage_next;
            fault <= fault_next;
            mem_en <= !fault_next && (stage_next == FETCH ||
                      (stage_next == MEMORY && (dec_mem_read || dec_mem_write)));
            dec_en <= !fault_next && stage_next == DECODE;
            rf_read_en <= !fault_next && stage_next == READ;
            alu_en <= !fault_next && stage_next == EXECUTE;
            rf_write_en <= !fault_next && stage_next == WRITE_BACK && dec_rd_write;
            pc_en <= !fault_next && stage_next == WRITE_BACK;
        end
    end

    assign branch_taken = alu_equal ^ dec_branch_ne;

    program_counter #(
        .MEM_WORDS(MEM_WORDS),
        .RESET_PC(RESET_PC)
    ) pc_unit (
        .clk(clk),
        .reset(reset),
        .en(pc_en),
        .pc_sel(dec_pc_sel),
        .imm(dec_imm),
        .alu_out(alu_result),
        .branch_taken(branch_taken),
        .pc(pc),
        .next_pc(next_pc),
        .fault(pc_fault)
    );

    assign mem_addr = (stage == MEMORY) ? alu_result : pc;
    assign mem_write = (stage == MEMORY) && dec_mem_write;

    memory #(
        .MEM_WORDS(MEM_WORDS)
    ) mem_unit (
        .clk(clk),
        .en(mem_en),
        .write(mem_write),
        .addr(mem_addr),
        .write_data(rf_read_b),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .read_data(mem_read_data),
        .fault(mem_fault)
    );

    instruction_decode dec_unit (
        .clk(clk),
        .en(dec_en),
        .instr(mem_read_data),
        .imm(dec_imm),
        .rs1(dec_rs1),
        .rs2(dec_rs2),
        .rd(dec_rd),
        .rd_write(dec_rd_write),
        .alu_a_pc(dec_alu_a_pc),
        .alu_b_imm(dec_alu_b_imm),
        .alu_op(dec_alu_op),
        .mem_read(dec_mem_read),
        .mem_write(dec_mem_write),
        .wb_sel(dec_wb_sel),
        .pc_sel(dec_pc_sel),
        .branch_ne(dec_branch_ne),
        .fault(dec_fault)
    );

    always_comb begin
        case (dec_wb_sel)
            WB_ALU:  wb_data = alu_result;
            WB_IMM:  wb_data = dec_imm;
            WB_MEM:  wb_data = mem_read_data;
            default: wb_data = next_pc;
        endcase
    end

    // a jump to a bad target must not leave its link value behind
    register_file rf_unit (
        .clk(clk),
        .read_en(rf_read_en),
        .write_en(rf_write_en && !pc_fault),
        .rs1(dec_rs1),
        .rs2(dec_rs2),
        .rd(dec_rd),
        .write_data(wb_data),
        .read_a(rf_read_a),
        .read_b(rf_read_b)
    );

    assign alu_a = dec_alu_a_pc ? pc : rf_read_a;
    assign alu_b = dec_alu_b_imm ? dec_imm : rf_read_b;

    alu alu_unit (
        .clk(clk),
        .en(alu_en),
        .op(dec_alu_op),
        .a(alu_a),
        .b(alu_b),
        .result(alu_result),
        .equal(alu_equal)
    );

    // pc_en is high only in WRITE_BACK, and a PC fault there cancels the retirement
    assign retire = pc_en && !pc_fault;
    assign retire_pc = pc;
    assign retire_rd = dec_rd_write ? dec_rd : 4'd0;
    assign retire_data = dec_rd_write ? wb_data : 32'd0;

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ns

module alu import core_pkg::*; (
    input  logic        clk,
    input  logic        en,
    input  alu_op_t     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        equal
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_ff @(posedge clk) begin
        if (en) begin
            // equal is kept for every op so branches can use any ALU encoding
            equal <= a == b;
            case (op)
                ALU_ADD:  result <= a + b;
                ALU_SUB:  result <= a - b;
                ALU_AND:  result <= a & b;
                ALU_OR:   result <= a | b;
                ALU_XOR:  result <= a ^ b;
                ALU_SLT:  result <= {31'd0, $signed(a) < $signed(b)};
                ALU_SLTU: result <= {31'd0, a < b};
                ALU_SLL:  result <= a << shamt;
                ALU_SRL:  result <= a >> shamt;
                ALU_SRA:  result <= $unsigned($signed(a) >>> shamt);
                default:  result <= b;
            endcase
        end
    end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic        clk,
    input  logic        read_en,
    input  logic        write_en,
    input  logic [3:0]  rs1,
    input  logic [3:0]  rs2,
    input  logic [3:0]  rd,
    input  logic [31:0] write_data,
    output logic [31:0] read_a,
    output logic [31:0] read_b
);

    logic [31:0] regs [16];

    // entry 0 is never written, the read path forces zero for it
    always_ff @(posedge clk) begin
        if (write_en && rd != 4'd0) begin
            regs[rd] <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (read_en) begin
            read_a <= (rs1 == 4'd0) ? 32'd0 : regs[rs1];
            read_b <= (rs2 == 4'd0) ? 32'd0 : regs[rs2];
        end
    end

endmodule

/* rtl/instruction_decode.sv */
`timescale 1ns/1ns

module instruction_decode import core_pkg::*; (
    input  logic        clk,
    input  logic        en,
    input  instr_t      instr,
    output logic [31:0] imm,
    output logic [3:0]  rs1,
    output logic [3:0]  rs2,
    output logic [3:0]  rd,
    output logic        rd_write,
    output logic        alu_a_pc,
    output logic        alu_b_imm,
    output alu_op_t     alu_op,
    output logic        mem_read,
    output logic        mem_write,
    output wb_sel_t     wb_sel,
    output pc_sel_t     pc_sel,
    output logic        branch_ne,
    output logic        fault
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_d;
    logic        a_pc_d;
    logic        b_imm_d;
    alu_op_t     op_d;
    logic        mem_read_d;
    logic        mem_write_d;
    wb_sel_t     wb_d;
    pc_sel_t     pc_d;
    logic        use_rs1;
    logic        use_rs2;
    logic        use_rd;
    logic        bad_op;

    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;

    // alt picks SUB over ADD and SRA over SRL
    function automatic alu_op_t alu_func(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        imm_d = {{20{instr.i.imm[11]}}, instr.i.imm};
        a_pc_d = 1'b0;
        b_imm_d = 1'b1;
        op_d = ALU_ADD;
        mem_read_d = 1'b0;
        mem_write_d = 1'b0;
        wb_d = WB_ALU;
        pc_d = PC_SEQ;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd = 1'b0;
        bad_op = 1'b0;
        case (instr.r.opcode)
            OP_REG: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd = 1'b1;
                b_imm_d = 1'b0;
                op_d = alu_func(funct3, funct7[5]);
                bad_op = !(funct7 == 7'b0000000 ||
                           (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OP_IMM: begin
                use_rs1 = 1'b1;
                use_rd = 1'b1;
                op_d = alu_func(funct3, funct3 == 3'b101 && funct7[5]);
                // for the shifts the upper immediate bits act as a funct7
                if (funct3 == 3'b001) begin
                    bad_op = funct7 != 7'b0000000;
                end else if (funct3 == 3'b101) begin
                    bad_op = funct7 != 7'b0000000 && funct7 != 7'b0100000;
                end
            end
            OP_LUI: begin
                use_rd = 1'b1;
                op_d = ALU_PASS_B;
                wb_d = WB_IMM;
                imm_d = {instr.u.imm, 12'b0};
            end
            OP_AUIPC: begin
                use_rd = 1'b1;
                a_pc_d = 1'b1;
                imm_d = {instr.u.imm, 12'b0};
            end
            OP_LOAD: begin
                use_rs1 = 1'b1;
                use_rd = 1'b1;
                mem_read_d = 1'b1;
                wb_d = WB_MEM;
                bad_op = funct3 != 3'b010;
            end
            OP_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                mem_write_d = 1'b1;
                imm_d = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                bad_op = funct3 != 3'b010;
            end
            OP_BRANCH: begin
                // the ALU only supplies the equality of rs1 and rs2 here
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                b_imm_d = 1'b0;
                op_d = ALU_SUB;
                pc_d = PC_BRANCH;
                imm_d = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                         instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
                bad_op = funct3[2:1] != 2'b00;
            end
            OP_JAL: begin
                use_rd = 1'b1;
                a_pc_d = 1'b1;
                wb_d = WB_PC;
                pc_d = PC_JUMP;
                imm_d = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                         instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            OP_JALR: begin
                use_rs1 = 1'b1;
                use_rd = 1'b1;
                wb_d = WB_PC;
                pc_d = PC_JUMP;
                bad_op = funct3 != 3'b000;
            end
            default: begin
                bad_op = 1'b1;
                pc_d = PC_HOLD;
            end
        endcase
    end

    // RV32E has sixteen registers, so bit 4 of a used register field is illegal
    assign fault = en && (bad_op || (use_rs1 && instr.r.rs1[4]) ||
                          (use_rs2 && instr.r.rs2[4]) || (use_rd && instr.r.rd[4]));

    always_ff @(posedge clk) begin
        if (en) begin
            imm <= imm_d;
            rs1 <= instr.r.rs1[3:0];
            rs2 <= instr.r.rs2[3:0];
            rd <= instr.r.rd[3:0];
            // a write to x0 counts as no destination at all
            rd_write <= use_rd && instr.r.rd != 5'd0;
            alu_a_pc <= a_pc_d;
            alu_b_imm <= b_imm_d;
            alu_op <= op_d;
            mem_read <= mem_read_d;
            mem_write <= mem_write_d;
            wb_sel <= wb_d;
            pc_sel <= pc_d;
            branch_ne <= funct3[0];
        end
    end

endmodule

/* rtl/memory.sv */
`timescale 1ns/1ns

module memory import core_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        en,
    input  logic        write,
    input  logic [31:0] addr,
    input  logic [31:0] write_data,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    output instr_t      read_data,
    output logic        fault
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];

    // both ports take byte addresses, the word index starts at bit 2
    assign fault = en && (addr[1:0] != 2'b00 || addr[31:2] >= MEM_WORDS);

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[AW+1:2]] <= load_data;
        end else if (en && !fault) begin
            if (write) begin
                mem[addr[AW+1:2]] <= write_data;
            end else begin
                read_data <= mem[addr[AW+1:2]];
            end
        end
    end

endmodule

/* rtl/program_counter.sv */
`timescale 1ns/1ns

module program_counter import core_pkg::*; #(
    parameter int          MEM_WORDS = 256,
    parameter logic [31:0] RESET_PC  = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        en,
    input  pc_sel_t     pc_sel,
    input  logic [31:0] imm,
    input  logic [31:0] alu_out,
    input  logic        branch_taken,
    output logic [31:0] pc,
    output logic [31:0] next_pc,
    output logic        fault
);

    logic [31:0] target;

    assign next_pc = pc + 32'd4;

    always_comb begin
        case (pc_sel)
            PC_SEQ:    target = next_pc;
            // JALR clears bit 0 of the computed address, JAL's target is even anyway
            PC_JUMP:   target = {alu_out[31:1], 1'b0};
            PC_BRANCH: target = branch_taken ? pc + imm : next_pc;
            default:   target = pc;
        endcase
    end

    // a bad target is reported and the PC keeps its old value
    assign fault = en && (target[1:0] != 2'b00 || target[31:2] >= MEM_WORDS);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (en && !fault) begin
            pc <= target;
        end
    end

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    // the stages are one-hot so the stage order reads straight off the bits
    typedef enum logic [5:0] {
        FETCH      = 6'b000001,
        DECODE     = 6'b000010,
        READ       = 6'b000100,
        EXECUTE    = 6'b001000,
        MEMORY     = 6'b010000,
        WRITE_BACK = 6'b100000
    } stage_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_MEM, WB_PC} wb_sel_t;

    // PC_JUMP takes the ALU result, PC_BRANCH takes pc + imm when the branch is taken
    typedef enum logic [1:0] {PC_SEQ, PC_JUMP, PC_BRANCH, PC_HOLD} pc_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // the same instruction word seen through each encoding format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_t;

endpackage
